//--- list.f
+incdir+.
vga_bus_pkg.sv
vga_video_pkg.sv
vga_regs.sv
vga_timing.sv
vga_line_fetch.sv
vga_scanout.sv
mod_vga.sv
vga_properties.sv
vga_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wall -f list.f --top-module vga_tb

obj_dir/Vvga_tb: list.f *.sv *.svh
	verilator --binary --timing --assert -f list.f --top-module vga_tb -o Vvga_tb

sim: obj_dir/Vvga_tb
	./obj_dir/Vvga_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- vga_tb.sv
/* directed testbench for mod_vga: SRAM model, register access tasks and
   frame-level checks of sync timing, blanking and pixel content */
`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_tb import vga_bus_pkg::*; import vga_video_pkg::*; ();

	localparam int LINE_CYC  = `VGA_H_PERIOD;
	localparam int FRAME_CYC = `VGA_H_PERIOD * `VGA_V_PERIOD;
	localparam int H_OFF     = `VGA_H_PULSE + `VGA_H_BACK;
	localparam int V_OFF     = `VGA_V_PULSE + `VGA_V_BACK;
	// sync 3, disabled 2, pixels 2, blanking 1, pointer 2, plus 2 frames of slack
	localparam real TIMEOUT_NS = 12.0 * FRAME_CYC * 8.0 + 1.0e6;

	logic       clk;
	logic       rst;
	logic       de;
	logic       drw;
	bus_addr_t  daddr;
	bus_data_t  din;
	bus_data_t  dout;
	sram_word_t sram_data;
	sram_addr_t sram_addr;
	logic       sram_read;
	logic       sram_rdy;
	pixel_t     rgb;
	logic       hs;
	logic       vs;

	integer seed;
	int     pos;    // output position in cycles since the vs falling edge
	logic   vs_d;

	mod_vga dut0 (
		.clk(clk), .rst(rst), .de(de), .drw(drw), .daddr(daddr), .din(din),
		.dout(dout), .sram_data(sram_data), .sram_addr(sram_addr),
		.sram_read(sram_read), .sram_rdy(sram_rdy), .rgb(rgb), .hs(hs), .vs(vs)
	);

	always #4 clk = ~clk;

	// SRAM model with data tied to the address and ready about one cycle in two
	assign sram_data = sram_addr ^ 32'h5a5a_0000;
	always @(posedge clk)
		sram_rdy <= 1'($random(seed));

	always @(negedge clk) begin
		if (vs_d && !vs)
			pos = 0;
		else
			pos = pos + 1;
		vs_d = vs;
	end

	// any failed bound assertion ends the run
	always @(negedge clk) begin
		if (dut0.props0.fail_count != 0) begin
			$display("a concurrent assertion on mod_vga failed");
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$fatal(1);
	end

	task automatic check_word(input bus_data_t got, input bus_data_t exp, input string msg);
		if (got !== exp) begin
			$display("Error at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string msg);
		if (got !== exp) begin
			$display("Error at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("Error at %0t: %s, got %b expected %b", $time, msg, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	function automatic pixel_t expect_pixel(input sram_addr_t ptr, input int x, input int y);
		sram_addr_t addr;
		sram_word_t word;
		addr = ptr + sram_addr_t'(y * `VGA_H_VISIBLE) + sram_addr_t'((x / 4) * 4);
		word = addr ^ 32'h5a5a_0000;
		return word[8 * (3 - x % 4) +: 8];
	endfunction

	task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
		@(posedge clk);
		de <= 1'b1;
		drw <= 1'b1;
		daddr <= addr;
		din <= data;
		@(posedge clk);
		de <= 1'b0;
		drw <= 1'b0;
	endtask

	task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
		@(posedge clk);
		de <= 1'b1;
		drw <= 1'b0;
		daddr <= addr;
		@(negedge clk);
		data = dout;
		@(posedge clk);
		de <= 1'b0;
	endtask

	// rgb seen at a posedge belongs to the counter position held in pos
	task automatic wait_pos(input int target);
		@(posedge clk);
		while (pos != target)
			@(posedge clk);
	endtask

	task automatic compare_rgb_at(input int h, input int v, input pixel_t exp,
			input string msg);
		wait_pos(v * LINE_CYC + h);
		check_pixel(rgb, exp, msg);
	endtask

	task automatic measure_sync(input bit use_vs, output int low, output int period);
		logic cur;
		logic prev;
		prev = use_vs ? vs : hs;
		forever begin
			@(posedge clk);
			cur = use_vs ? vs : hs;
			if (prev && !cur)
				break;
			prev = cur;
		end
		low = 0;
		period = 0;
		prev = 1'b0;
		forever begin
			@(posedge clk);
			period++;
			cur = use_vs ? vs : hs;
			if (!cur)
				low++;
			if (!prev && cur)
				prev = 1'b1;
			else if (prev && !cur)
				break;
		end
	endtask

	task automatic regs_readback();
		bus_data_t val;
		bus_data_t got;
		val = $random(seed);
		write_reg(`VGA_REG_CTRL, val);
		read_reg(`VGA_REG_CTRL, got);
		check_word(got, {31'b0, val[0]}, "control readback");
		val = $random(seed);
		write_reg(`VGA_REG_FB, val);
		read_reg(`VGA_REG_FB, got);
		check_word(got, val, "pointer readback");
		@(negedge clk);
		check_word(dout, '0, "dout while deselected");
		write_reg(`VGA_REG_CTRL, 32'h0);
	endtask

	task automatic sync_timing();
		int low;
		int period;
		measure_sync(1'b0, low, period);
		check_word(bus_data_t'(low), 96, "hs low width");
		check_word(bus_data_t'(period), LINE_CYC, "hs period");
		measure_sync(1'b1, low, period);
		check_word(bus_data_t'(low), 2 * LINE_CYC, "vs low width");
		check_word(bus_data_t'(period), FRAME_CYC, "vs period");
	endtask

	task automatic disabled_frame();
		write_reg(`VGA_REG_FB, 32'h0001_0000);
		wait_pos(0);
		repeat (FRAME_CYC) begin
			check_pixel(rgb, '0, "rgb while disabled");
			@(posedge clk);
		end
	endtask

	task automatic pixel_content();
		sram_addr_t ptr;
		ptr = 32'h0001_0000;
		write_reg(`VGA_REG_CTRL, 32'h1);
		wait_pos(0);
		compare_rgb_at(H_OFF, V_OFF, expect_pixel(ptr, 0, 0), "pixel 0,0");
		compare_rgb_at(H_OFF + 5, V_OFF + 1, expect_pixel(ptr, 5, 1), "pixel 5,1");
		compare_rgb_at(H_OFF + 322, V_OFF + 77, expect_pixel(ptr, 322, 77), "pixel 322,77");
		compare_rgb_at(H_OFF + 639, V_OFF + 240, expect_pixel(ptr, 639, 240), "pixel 639,240");
		compare_rgb_at(H_OFF + 3, V_OFF + 479, expect_pixel(ptr, 3, 479), "pixel 3,479");
	endtask

	task automatic blank_regions();
		wait_pos(0);
		compare_rgb_at(400, 5, '0, "vertical blank line");
		compare_rgb_at(10, 100, '0, "sync pulse column");
		compare_rgb_at(H_OFF - 1, 100, '0, "back porch column");
		compare_rgb_at(H_OFF + 640, 100, '0, "front porch column");
		compare_rgb_at(799, 100, '0, "last column");
		compare_rgb_at(400, 511, '0, "bottom porch line");
		compare_rgb_at(400, 520, '0, "last line");
	endtask

	task automatic pointer_switch();
		sram_addr_t old_ptr;
		sram_addr_t new_ptr;
		old_ptr = 32'h0001_0000;
		new_ptr = 32'h0008_0000;
		wait_pos(0);
		compare_rgb_at(H_OFF + 17, V_OFF + 50, expect_pixel(old_ptr, 17, 50),
			"old base line 50");
		compare_rgb_at(H_OFF + 9, V_OFF + 120, expect_pixel(old_ptr, 9, 120),
			"old base line 120");
		wait_pos((V_OFF + 150) * LINE_CYC + 400);
		write_reg(`VGA_REG_FB, new_ptr); // lands during visible line 150
		compare_rgb_at(H_OFF + 30, V_OFF + 160, expect_pixel(new_ptr, 30, 160),
			"new base line 160");
		compare_rgb_at(H_OFF + 601, V_OFF + 300, expect_pixel(new_ptr, 601, 300),
			"new base line 300");
	endtask

	initial begin
		seed = 32'ha81a;
		clk = 1'b0;
		rst = 1'b1;
		de = 1'b0;
		drw = 1'b0;
		daddr = '0;
		din = '0;
		sram_rdy = 1'b0;
		pos = 0;
		vs_d = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_bit(vs, 1'b0, "vs after reset");
		check_bit(sram_read, 1'b0, "sram_read after reset");
		regs_readback();
		sync_timing();
		disabled_frame();
		pixel_content();
		blank_regions();
		pointer_switch();
		if (dut0.props0.fail_count != 0) begin
			$display("a concurrent assertion on mod_vga failed");
			$display("TESTS FAILED");
			$fatal(1);
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- vga_properties.sv
/* concurrent checks on the SRAM fetch port and the blanked output,
   attached to every mod_vga instance by bind */
`timescale 1ns/1ps
`default_nettype none

module vga_properties import vga_bus_pkg::*; import vga_video_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       sram_read,
	input logic       sram_rdy,
	input sram_addr_t sram_addr,
	input logic       line_start,
	input logic       blank,
	input pixel_t     rgb
);

	int fail_count = 0; // failed assertion count

	// a fetch only starts at a line start, never after one has finished
	read_rise_at_line_start: assert property (@(posedge clk) disable iff (rst)
		$rose(sram_read) |-> $past(line_start))
		else begin
			fail_count++;
			$error("sram_read rose outside a line start");
		end

	blank_gives_black: assert property (@(posedge clk) disable iff (rst)
		$past(blank) && !$past(rst) |-> rgb == '0)
		else begin
			fail_count++;
			$error("rgb not zero during blank");
		end

	// address holds while waiting, except when a new line reloads it
	addr_stable_on_stall: assert property (@(posedge clk) disable iff (rst)
		sram_read && !sram_rdy && !line_start |=> sram_addr == $past(sram_addr))
		else begin
			fail_count++;
			$error("sram_addr changed during a stall");
		end

endmodule

bind mod_vga vga_properties props0 (
	.clk(clk), .rst(rst), .sram_read(sram_read), .sram_rdy(sram_rdy),
	.sram_addr(sram_addr), .line_start(line_start), .blank(blank), .rgb(rgb)
);

`default_nettype wire

//--- mod_vga.sv
/* VGA display peripheral top: register file, timing generator, SRAM line
   fetch and output stage; sits on the processor data port and an SRAM read port */
`timescale 1ns/1ps
`default_nettype none

module mod_vga
	import vga_bus_pkg::*;
	import vga_video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       de,
	input  logic       drw,
	input  bus_addr_t  daddr,
	input  bus_data_t  din,
	output bus_data_t  dout,
	input  sram_word_t sram_data,
	output sram_addr_t sram_addr,
	output logic       sram_read,
	input  logic       sram_rdy,
	output pixel_t     rgb,
	output logic       hs,
	output logic       vs
);

	logic       enable;
	sram_addr_t fb_pointer;
	logic       hs_raw;
	logic       vs_raw;
	logic       blank;
	logic       line_start;
	coord_t     hcount;
	coord_t     vcount_next;
	logic       fetch_valid;
	pixel_t     pix;

	vga_regs regs0 (
		.clk        (clk),
		.rst        (rst),
		.de         (de),
		.drw        (drw),
		.daddr      (daddr),
		.din        (din),
		.dout       (dout),
		.enable     (enable),
		.fb_pointer (fb_pointer)
	);

	vga_timing timing0 (
		.clk         (clk),
		.rst         (rst),
		.hs_raw      (hs_raw),
		.vs_raw      (vs_raw),
		.blank       (blank),
		.line_start  (line_start),
		.hcount      (hcount),
		.vcount      (),
		.vcount_next (vcount_next),
		.fetch_valid (fetch_valid)
	);

	vga_line_fetch fetch0 (
		.clk         (clk),
		.rst         (rst),
		.line_start  (line_start),
		.vcount_next (vcount_next),
		.fetch_valid (fetch_valid),
		.fb_pointer  (fb_pointer),
		.hcount      (hcount),
		.pix         (pix),
		.sram_data   (sram_data),
		.sram_addr   (sram_addr),
		.sram_read   (sram_read),
		.sram_rdy    (sram_rdy)
	);

	vga_scanout scanout0 (
		.clk    (clk),
		.rst    (rst),
		.hs_raw (hs_raw),
		.vs_raw (vs_raw),
		.blank  (blank),
		.enable (enable),
		.pix    (pix),
		.hs     (hs),
		.vs     (vs),
		.rgb    (rgb)
	);

endmodule

`default_nettype wire

//--- vga_scanout.sv
/* output stage: registers sync together with the pixel and blanks rgb
   outside the visible area or while the display is disabled */
`timescale 1ns/1ps
`default_nettype none

module vga_scanout import vga_video_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   hs_raw,
	input  logic   vs_raw,
	input  logic   blank,
	input  logic   enable,
	input  pixel_t pix,
	output logic   hs,
	output logic   vs,
	output pixel_t rgb
);

	always_ff @(posedge clk) begin
		if (rst) begin
			hs  <= 1'b0; // counter 0 sits in both sync pulses
			vs  <= 1'b0;
			rgb <= '0;
		end else begin
			hs <= hs_raw;
			vs <= vs_raw;
			if (blank || !enable)
				rgb <= '0;
			else
				rgb <= pix;
		end
	end

endmodule

`default_nettype wire

//--- vga_line_fetch.sv
/* ping-pong line buffer: fetches the next visible line from SRAM into the
   back bank while the front bank feeds pixels, swapping at each line start */
`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_line_fetch
	import vga_bus_pkg::*;
	import vga_video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       line_start,
	input  coord_t     vcount_next,
	input  logic       fetch_valid,
	input  sram_addr_t fb_pointer,
	input  coord_t     hcount,
	output pixel_t     pix,
	input  sram_word_t sram_data,
	output sram_addr_t sram_addr,
	output logic       sram_read,
	input  logic       sram_rdy
);

	sram_word_t line_buf [0:1][0:`VGA_LINE_WORDS-1];

	logic       bank;     // front bank, shown on screen
	logic       back;
	word_idx_t  wr_idx;   // next word to fill in the back bank
	sram_addr_t line_base;
	word_idx_t  rd_idx;
	sram_word_t rd_word;

	assign back = ~bank;

	// byte offset of the line to fetch
	assign line_base = fb_pointer + sram_addr_t'(vcount_next) * sram_addr_t'(`VGA_H_VISIBLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			bank      <= 1'b0;
			sram_read <= 1'b0;
			wr_idx    <= '0;
			sram_addr <= '0;
		end else if (line_start) begin
			bank      <= ~bank; // unfinished fetch is dropped here
			sram_read <= fetch_valid;
			wr_idx    <= '0;
			sram_addr <= line_base;
		end else if (sram_read && sram_rdy) begin
			sram_addr <= sram_addr + 32'd4;
			wr_idx    <= wr_idx + 1'b1;
			if (wr_idx == word_idx_t'(`VGA_LINE_WORDS - 1))
				sram_read <= 1'b0; // last word of the line taken
		end
	end

	// back bank fill from SRAM
	always_ff @(posedge clk) begin
		if (!line_start && sram_read && sram_rdy)
			line_buf[back][wr_idx] <= sram_data;
	end

	assign rd_idx  = hcount[9:2];
	assign rd_word = line_buf[bank][rd_idx];

	// most significant byte is the leftmost pixel
	always_comb begin
		case (hcount[1:0])
			2'd0:    pix = rd_word[31:24];
			2'd1:    pix = rd_word[23:16];
			2'd2:    pix = rd_word[15:8];
			default: pix = rd_word[7:0];
		endcase
	end

endmodule

`default_nettype wire

//--- vga_timing.sv
/* 640x480 horizontal and vertical counters; derives sync, blank and visible
   coordinates, plus the line start pulse and next-line info for the fetch unit */
`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_timing import vga_video_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	output logic   hs_raw,
	output logic   vs_raw,
	output logic   blank,
	output logic   line_start,
	output coord_t hcount,
	output coord_t vcount,
	output coord_t vcount_next,
	output logic   fetch_valid
);

	localparam int H_VIS_START = `VGA_H_PULSE + `VGA_H_BACK;   // 144
	localparam int H_VIS_END   = `VGA_H_PERIOD - `VGA_H_FRONT; // 784
	localparam int V_VIS_START = `VGA_V_PULSE + `VGA_V_BACK;   // 31
	localparam int V_VIS_END   = `VGA_V_PERIOD - `VGA_V_FRONT; // 511

	coord_t hcounter;
	coord_t vcounter;
	logic   h_vis;
	logic   v_vis;

	always_ff @(posedge clk) begin
		if (rst) begin
			hcounter <= '0;
			vcounter <= '0;
		end else if (hcounter == coord_t'(`VGA_H_PERIOD - 1)) begin
			hcounter <= '0;
			if (vcounter == coord_t'(`VGA_V_PERIOD - 1))
				vcounter <= '0; // exactly V_PERIOD lines per frame
			else
				vcounter <= vcounter + 1'b1;
		end else begin
			hcounter <= hcounter + 1'b1;
		end
	end

	assign hs_raw = (hcounter >= coord_t'(`VGA_H_PULSE)); // low during the pulse
	assign vs_raw = (vcounter >= coord_t'(`VGA_V_PULSE));

	assign h_vis = (hcounter >= coord_t'(H_VIS_START)) && (hcounter < coord_t'(H_VIS_END));
	assign v_vis = (vcounter >= coord_t'(V_VIS_START)) && (vcounter < coord_t'(V_VIS_END));
	assign blank = !(h_vis && v_vis);

	// coordinates are zero outside the visible region
	assign hcount = h_vis ? hcounter - coord_t'(H_VIS_START) : '0;
	assign vcount = v_vis ? vcounter - coord_t'(V_VIS_START) : '0;

	assign line_start = (hcounter == '0);

	// the line after this one is visible when this one is V_VIS_START-1 .. V_VIS_END-2
	assign fetch_valid = (vcounter >= coord_t'(V_VIS_START - 1)) &&
		(vcounter < coord_t'(V_VIS_END - 1));
	assign vcount_next = fetch_valid ? vcounter - coord_t'(V_VIS_START - 1) : '0;

endmodule

`default_nettype wire

//--- vga_regs.sv
/* control and frame buffer pointer registers of the VGA peripheral,
   written and read back over the processor data port */
`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_regs import vga_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       de,
	input  logic       drw,
	input  bus_addr_t  daddr,
	input  bus_data_t  din,
	output bus_data_t  dout,
	output logic       enable,
	output sram_addr_t fb_pointer
);

	logic wr_ctrl;
	logic wr_fb;
	logic rd_sel;

	assign wr_ctrl = de && drw && (daddr == `VGA_REG_CTRL);
	assign wr_fb   = de && drw && (daddr == `VGA_REG_FB);
	assign rd_sel  = de && !drw;

	always_ff @(posedge clk) begin
		if (rst) begin
			enable     <= 1'b0;
			fb_pointer <= '0;
		end else begin
			if (wr_ctrl)
				enable <= din[0]; // only bit 0 is implemented
			if (wr_fb)
				fb_pointer <= din;
		end
	end

	// readback is zero unless selected, so the system can OR peripherals
	always_comb begin
		dout = '0;
		if (rd_sel) begin
			if (daddr == `VGA_REG_CTRL)
				dout = {31'b0, enable};
			else if (daddr == `VGA_REG_FB)
				dout = fb_pointer;
		end
	end

endmodule

`default_nettype wire

//--- vga_video_pkg.sv
/* video-side types for the VGA peripheral: pixels, screen coordinates
   and word indices into a line buffer */
`default_nettype none

package vga_video_pkg;

	typedef logic [7:0] pixel_t; // one 8-bit colour value

	// wide enough for both the 800-clock line and the 521-line frame
	typedef logic [10:0] coord_t;

	typedef logic [7:0] word_idx_t; // 0 to 159 within a line

endpackage

`default_nettype wire

//--- vga_bus_pkg.sv
/* bus-side types for the VGA peripheral: the processor data port
   and the SRAM read port */
`default_nettype none

package vga_bus_pkg;

	// processor data port
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// SRAM read port, byte addressed
	typedef logic [31:0] sram_addr_t;
	typedef logic [31:0] sram_word_t;

endpackage

`default_nettype wire

//--- vga_params.svh
/* timing, geometry and register offset constants for the VGA peripheral,
   included by any file that needs the 640x480 numbers or register map */
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// horizontal timing, in pixel clocks
`define VGA_H_PULSE   96
`define VGA_H_BACK    48
`define VGA_H_FRONT   16
`define VGA_H_PERIOD  800

// vertical timing, in lines
`define VGA_V_PULSE   2
`define VGA_V_BACK    29
`define VGA_V_FRONT   10
`define VGA_V_PERIOD  521

// visible area
`define VGA_H_VISIBLE 640
`define VGA_V_VISIBLE 480

`define VGA_LINE_WORDS 160 // 32-bit words per line, 4 pixels each

// register offsets on daddr
`define VGA_REG_CTRL 0
`define VGA_REG_FB   4

`endif
